/* Bender.yml */
package:
  name: chain_sum

sources:
  - src/chain_sum_pkg.sv
  - src/sum_ctrl_if.sv
  - src/ripple_adder.sv
  - src/sum_controller.sv
  - src/sum_datapath.sv
  - src/chain_sum_top.sv

  - target: test
    files:
      - tb/chain_sum_tb.sv

/* project.f */
src/chain_sum_pkg.sv
src/sum_ctrl_if.sv
src/ripple_adder.sv
src/sum_controller.sv
src/sum_datapath.sv
src/chain_sum_top.sv
tb/chain_sum_tb.sv

/* src/chain_sum_pkg.sv */
package chain_sum_pkg;

    //////////////////////////////////////////////////
    // tree shape
    //////////////////////////////////////////////////

    localparam int OPERAND_COUNT = 8;
    localparam int TREE_LEVELS = 3;           // log2 of OPERAND_COUNT

    localparam int DEFAULT_OPERAND_WIDTH = 4;

    //////////////////////////////////////////////////
    // controller and adder select encodings
    //////////////////////////////////////////////////

    typedef enum logic [2:0] {
        st_idle,
        st_load,
        st_calc_1,
        st_calc_2,
        st_calc_3,
        st_done
    } sum_state_e;

    // inputs of the two shared adders
    typedef enum logic [1:0] {
        sel_operand,
        sel_level_1,
        sel_level_2
    } adder_sel_e;

endpackage

/* src/chain_sum_top.sv */
module chain_sum_top import chain_sum_pkg::*; #(
    parameter int OPERAND_WIDTH = DEFAULT_OPERAND_WIDTH
) (
    input  logic                                   clk,
    input  logic                                   reset,
    input  logic                                   in_valid,
    input  logic [OPERAND_COUNT*OPERAND_WIDTH-1:0] operands,  // operand 0 in low bits
    output logic [OPERAND_WIDTH+TREE_LEVELS-1:0]   sum,
    output logic                                   sum_valid
);

    // in_valid must stay low during the calc stages, no back-pressure

    sum_ctrl_if ctrl_bus ();

    //////////////////////////////////////////////////
    // controller
    //////////////////////////////////////////////////

    sum_controller controller_i (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .ctrl      (ctrl_bus.ctrl),
        .sum_valid (sum_valid)
    );

    //////////////////////////////////////////////////
    // datapath
    //////////////////////////////////////////////////

    sum_datapath #(
        .OPERAND_WIDTH (OPERAND_WIDTH)
    ) datapath_i (
        .clk      (clk),
        .reset    (reset),
        .operands (operands),
        .ctrl     (ctrl_bus.data),
        .sum      (sum)
    );

endmodule

/* src/ripple_adder.sv */
module ripple_adder #(
    parameter int WIDTH = 4
) (
    input  logic [WIDTH-1:0] a,
    input  logic [WIDTH-1:0] b,
    output logic [WIDTH:0]   sum
);

    logic [WIDTH:0] carry;

    assign carry[0] = 1'b0;  // no carry in

    //////////////////////////////////////////////////
    // full adder chain
    //////////////////////////////////////////////////

    for (genvar i = 0; i < WIDTH; i++) begin : g_bit
        assign sum[i] = a[i] ^ b[i] ^ carry[i];
        assign carry[i+1] = (a[i] & b[i])
                          | (a[i] & carry[i])
                          | (b[i] & carry[i]);
    end

    assign sum[WIDTH] = carry[WIDTH];

endmodule

/* src/sum_controller.sv */
module sum_controller import chain_sum_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  logic     in_valid,
    sum_ctrl_if.ctrl ctrl,
    output logic     sum_valid
);

    sum_state_e state;
    sum_state_e state_next;

    //////////////////////////////////////////////////
    // state register
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= st_idle;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            st_idle: begin
                if (in_valid) begin
                    state_next = st_load;
                end
            end
            st_load: begin
                if (!in_valid) begin
                    state_next = st_calc_1;  // last capture was on this edge's predecessor
                end
            end
            st_calc_1: begin
                state_next = st_calc_2;
            end
            st_calc_2: begin
                state_next = st_calc_3;
            end
            st_calc_3: begin
                state_next = st_done;
            end
            st_done: begin
                if (in_valid) begin
                    state_next = st_load;    // next job
                end
            end
            default: begin
                state_next = st_idle;
            end
        endcase
    end

    //////////////////////////////////////////////////
    // enable and select decode
    //////////////////////////////////////////////////

    always_comb begin
        ctrl.load_ops     = 1'b0;
        ctrl.load_level_1 = 1'b0;
        ctrl.load_level_2 = 1'b0;
        ctrl.load_sum     = 1'b0;
        ctrl.adder_sel    = sel_operand;
        sum_valid         = 1'b0;
        case (state)
            st_idle, st_load: begin
                ctrl.load_ops = in_valid;
            end
            st_calc_1: begin
                ctrl.load_level_1 = 1'b1;      // operands 0..3 through shared adders
                ctrl.adder_sel    = sel_operand;
            end
            st_calc_2: begin
                ctrl.load_level_2 = 1'b1;
                ctrl.adder_sel    = sel_level_1;
            end
            st_calc_3: begin
                ctrl.load_sum  = 1'b1;
                ctrl.adder_sel = sel_level_2;
            end
            st_done: begin
                ctrl.load_ops = in_valid;
                sum_valid     = 1'b1;
            end
            default: begin
                ctrl.load_ops = 1'b0;
            end
        endcase
    end

    //////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////

    // shared adders can feed only one level per cycle
    a_level_loads_exclusive: assert property (@(posedge clk) disable iff (reset)
        $onehot0({ctrl.load_level_1, ctrl.load_level_2, ctrl.load_sum}));

    // valid only in st_done, and only once the sum register has been written
    a_valid_after_sum: assert property (@(posedge clk) disable iff (reset)
        sum_valid |-> (state == st_done) && ($past(ctrl.load_sum) || $past(sum_valid)));

endmodule

/* src/sum_ctrl_if.sv */
interface sum_ctrl_if import chain_sum_pkg::*; ();

    logic       load_ops;      // operand bank capture
    logic       load_level_1;  // four level-one partial sums
    logic       load_level_2;  // two level-two partial sums
    logic       load_sum;      // final sum register
    adder_sel_e adder_sel;

    modport ctrl (
        output load_ops,
        output load_level_1,
        output load_level_2,
        output load_sum,
        output adder_sel
    );

    modport data (
        input load_ops,
        input load_level_1,
        input load_level_2,
        input load_sum,
        input adder_sel
    );

endinterface

/* src/sum_datapath.sv */
module sum_datapath import chain_sum_pkg::*; #(
    parameter int OPERAND_WIDTH = DEFAULT_OPERAND_WIDTH
) (
    input  logic                                   clk,
    input  logic                                   reset,
    input  logic [OPERAND_COUNT*OPERAND_WIDTH-1:0] operands,
    sum_ctrl_if.data                               ctrl,
    output logic [OPERAND_WIDTH+TREE_LEVELS-1:0]   sum
);

    localparam int SUM_WIDTH = OPERAND_WIDTH + TREE_LEVELS;
    localparam int LEVEL_1_COUNT = OPERAND_COUNT / 2;
    localparam int LEVEL_2_COUNT = OPERAND_COUNT / 4;

    logic [OPERAND_WIDTH-1:0] op_q      [OPERAND_COUNT];
    logic [SUM_WIDTH-1:0]     level_1_q [LEVEL_1_COUNT];
    logic [SUM_WIDTH-1:0]     level_2_q [LEVEL_2_COUNT];
    logic [SUM_WIDTH-1:0]     sum_q;

    logic [SUM_WIDTH-1:0]     shared_a   [2];
    logic [SUM_WIDTH-1:0]     shared_b   [2];
    logic [SUM_WIDTH:0]       shared_sum [2];
    logic [OPERAND_WIDTH:0]   fixed_sum  [2];   // operands 4+5 and 6+7

    //////////////////////////////////////////////////
    // shared adder operand select
    //////////////////////////////////////////////////

    always_comb begin
        shared_a[0] = '0;
        shared_b[0] = '0;
        shared_a[1] = '0;
        shared_b[1] = '0;
        case (ctrl.adder_sel)
            sel_operand: begin
                shared_a[0] = SUM_WIDTH'(op_q[0]);
                shared_b[0] = SUM_WIDTH'(op_q[1]);
                shared_a[1] = SUM_WIDTH'(op_q[2]);
                shared_b[1] = SUM_WIDTH'(op_q[3]);
            end
            sel_level_1: begin
                shared_a[0] = level_1_q[0];
                shared_b[0] = level_1_q[1];
                shared_a[1] = level_1_q[2];
                shared_b[1] = level_1_q[3];
            end
            sel_level_2: begin
                shared_a[0] = level_2_q[0];  // second adder idles here
                shared_b[0] = level_2_q[1];
            end
            default: begin
                shared_a[0] = '0;
            end
        endcase
    end

    for (genvar i = 0; i < 2; i++) begin : g_shared
        ripple_adder #(.WIDTH(SUM_WIDTH)) adder_i (
            .a   (shared_a[i]),
            .b   (shared_b[i]),
            .sum (shared_sum[i])
        );
    end

    for (genvar i = 0; i < 2; i++) begin : g_fixed
        ripple_adder #(.WIDTH(OPERAND_WIDTH)) adder_i (
            .a   (op_q[4 + 2*i]),
            .b   (op_q[5 + 2*i]),
            .sum (fixed_sum[i])
        );
    end

    //////////////////////////////////////////////////
    // operand bank and partial sums
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < OPERAND_COUNT; i++) begin
                op_q[i] <= '0;
            end
            for (int i = 0; i < LEVEL_1_COUNT; i++) begin
                level_1_q[i] <= '0;
            end
            for (int i = 0; i < LEVEL_2_COUNT; i++) begin
                level_2_q[i] <= '0;
            end
            sum_q <= '0;
        end else begin
            if (ctrl.load_ops) begin
                for (int i = 0; i < OPERAND_COUNT; i++) begin
                    op_q[i] <= operands[i*OPERAND_WIDTH +: OPERAND_WIDTH];
                end
            end
            if (ctrl.load_level_1) begin
                level_1_q[0] <= shared_sum[0][SUM_WIDTH-1:0];
                level_1_q[1] <= shared_sum[1][SUM_WIDTH-1:0];
                level_1_q[2] <= SUM_WIDTH'(fixed_sum[0]);
                level_1_q[3] <= SUM_WIDTH'(fixed_sum[1]);
            end
            if (ctrl.load_level_2) begin
                level_2_q[0] <= shared_sum[0][SUM_WIDTH-1:0];
                level_2_q[1] <= shared_sum[1][SUM_WIDTH-1:0];
            end
            if (ctrl.load_sum) begin
                sum_q <= shared_sum[0][SUM_WIDTH-1:0];  // carry out never set
            end
        end
    end

    assign sum = sum_q;

    // select from the controller must be a legal encoding whenever anything loads
    a_sel_legal: assert property (@(posedge clk) disable iff (reset)
        (ctrl.load_ops || ctrl.load_level_1 || ctrl.load_level_2 || ctrl.load_sum)
            |-> ctrl.adder_sel inside {sel_operand, sel_level_1, sel_level_2});

endmodule

/* tb/chain_sum_tb.sv */
module chain_sum_tb import chain_sum_pkg::*;;

    localparam int W = DEFAULT_OPERAND_WIDTH;
    localparam int N = OPERAND_COUNT;
    localparam int SW = W + TREE_LEVELS;
    localparam int PERIOD = 100;
    localparam int VALID_LIMIT = 10;            // edges allowed before sum_valid rises
    localparam int WATCHDOG_TIME = 40 * 12 * PERIOD;

    logic          clk;
    logic          reset;
    logic          in_valid;
    logic [N*W-1:0] operands;
    logic [SW-1:0] sum;
    logic          sum_valid;

    logic [SW-1:0] expected;                    // model result of the current job
    int            errors;
    int            tests;

    chain_sum_top dut_i (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .operands  (operands),
        .sum       (sum),
        .sum_valid (sum_valid)
    );

    always #(PERIOD / 2) clk = ~clk;

    //////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////

    function automatic logic [SW-1:0] model_sum(input logic [N*W-1:0] ops);
        logic [SW-1:0] total;
        total = '0;
        for (int i = 0; i < N; i++) begin
            total += SW'(ops[i*W +: W]);
        end
        return total;
    endfunction

    function automatic logic [N*W-1:0] random_operands();
        logic [N*W-1:0] ops;
        for (int i = 0; i < N; i++) begin
            ops[i*W +: W] = W'($urandom);
        end
        return ops;
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("** Error at %0t: %s expected %0d, got %0d", $time, name, exp, act);
            errors++;
        end
    endtask

    // one capture edge, called and returning on a falling edge
    task automatic apply_operands(input logic [N*W-1:0] ops);
        in_valid = 1'b1;
        operands = ops;
        expected = model_sum(ops);
        @(negedge clk);
    endtask

    task automatic wait_for_sum_valid(output int edges);
        edges = 0;
        do begin
            @(posedge clk);
            edges++;
            @(negedge clk);
        end while (!sum_valid && edges < VALID_LIMIT);
        if (!sum_valid) begin
            $display("sum_valid did not rise within %0d edges, at %0t", VALID_LIMIT, $time);
            errors++;
        end
    endtask

    // drop in_valid, wait for the result and compare with the model
    task automatic complete_job();
        int edges;
        in_valid = 1'b0;
        operands = random_operands();           // must not be captured
        wait_for_sum_valid(edges);
        check_value("edges to sum_valid", 4, edges);
        check_value("sum", expected, sum);
    endtask

    task automatic hold_idle(input int cycles);
        for (int i = 0; i < cycles; i++) begin
            @(negedge clk);
            check_value("sum_valid", 1, sum_valid);
            check_value("sum", expected, sum);
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        tests++;
        if (errors == errors_before) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, errors - errors_before);
        end
    endtask

    //////////////////////////////////////////////////
    // tests
    //////////////////////////////////////////////////

    task automatic test_after_reset();
        int errors_before;
        errors_before = errors;
        check_value("sum_valid", 0, sum_valid);
        check_value("sum", 0, sum);
        apply_operands({4'd1, 4'd2, 4'd3, 4'd4, 4'd5, 4'd6, 4'd7, 4'd8});
        complete_job();
        report_test("after reset", errors_before);
    endtask

    task automatic test_max_operands();
        int errors_before;
        errors_before = errors;
        apply_operands('1);
        expected = SW'(N * ((1 << W) - 1));      // full sum, 120 at four bits
        complete_job();
        report_test("largest operands", errors_before);
    endtask

    task automatic test_multi_cycle_load();
        int errors_before;
        errors_before = errors;
        apply_operands({4'd15, 4'd0, 4'd15, 4'd0, 4'd15, 4'd0, 4'd15, 4'd0});
        apply_operands({4'd9, 4'd9, 4'd9, 4'd9, 4'd9, 4'd9, 4'd9, 4'd9});
        apply_operands({4'd3, 4'd1, 4'd4, 4'd1, 4'd5, 4'd9, 4'd2, 4'd6});
        complete_job();
        report_test("multi-cycle load", errors_before);
    endtask

    task automatic test_back_to_back();
        int errors_before;
        errors_before = errors;
        check_value("sum_valid", 1, sum_valid);
        apply_operands(random_operands());
        check_value("sum_valid", 0, sum_valid);   // falls after the edge seeing in_valid
        apply_operands(random_operands());
        complete_job();
        report_test("back-to-back jobs", errors_before);
    endtask

    task automatic test_random_jobs();
        int errors_before;
        int load_len;
        errors_before = errors;
        for (int job = 0; job < 30; job++) begin
            load_len = $urandom_range(1, 4);
            for (int i = 0; i < load_len; i++) begin
                apply_operands(random_operands());
            end
            complete_job();
            hold_idle($urandom_range(0, 3));
        end
        report_test("random jobs", errors_before);
    endtask

    //////////////////////////////////////////////////
    // run
    //////////////////////////////////////////////////

    initial begin
        #(WATCHDOG_TIME);
        $display("watchdog expired at %0t, the tests did not finish", $time);
        $display("** FAIL **");
        $finish;
    end

    initial begin
        int seed_result;
        seed_result = $urandom(32'hfb4c_41cd);
        clk = 1'b0;
        reset = 1'b1;
        in_valid = 1'b0;
        operands = '0;
        expected = '0;
        errors = 0;
        tests = 0;
        repeat (5) @(negedge clk);
        reset = 1'b0;

        test_after_reset();
        test_max_operands();
        test_multi_cycle_load();
        test_back_to_back();
        test_random_jobs();

        $display("tests run %0d, errors %0d", tests, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule
